//--- Makefile
# Verilator build and run of the MAC lane testbench.

VERILATOR ?= verilator
TOP       ?= lenet_mac_lane_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
logic/lenet_mac_pkg.sv
logic/approx_mult_8x8.sv
logic/operand_issuer.sv
logic/credit_fifo.sv
logic/approx_mac.sv
logic/lenet_mac_lane.sv
testbench/lenet_mac_lane_tb.sv

//--- logic/approx_mac.sv
`timescale 1ns/1ps

module approx_mac
    import lenet_mac_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  operand_pair_t    pop_pair,
    input  logic             not_empty,
    output logic             pop,
    output logic             credit_return,
    input  logic             out_ready,
    output logic             sum_valid,
    output logic [ACC_W-1:0] sum
);

    logic [PRODUCT_W-1:0] product;
    logic [ACC_W-1:0]     acc;
    logic [ACC_W-1:0]     acc_next;
    logic                 window_done;

    approx_mult_8x8 i_mult (
        .activation (pop_pair.activation),
        .weight     (pop_pair.weight),
        .product    (product)
    );

    // a held sum blocks the pop unless it is taken this cycle.
    assign pop         = not_empty && (!sum_valid || out_ready);
    assign acc_next    = acc + ACC_W'(product);
    assign window_done = pop && pop_pair.last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accumulator, output handshake and credit return.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            acc           <= '0;
            sum_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
            if (window_done) begin
                acc <= '0;
            end else if (pop) begin
                acc <= acc_next;
            end
            // a new sum wins over the take of the old one.
            if (window_done) begin
                sum_valid <= 1'b1;
            end else if (out_ready) begin
                sum_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window_done) begin
            sum <= acc_next;
        end
    end

    // an untaken sum stays valid and unchanged.
    assert property (@(posedge clk) disable iff (reset)
        (sum_valid && !out_ready) |=> (sum_valid && $stable(sum)))
        else $error("approx_mac: held sum changed before it was taken");

endmodule

//--- logic/approx_mult_8x8.sv
`timescale 1ns/1ps

module approx_mult_8x8
    import lenet_mac_pkg::*;
(
    input  logic [OPERAND_W-1:0] activation,
    input  logic [OPERAND_W-1:0] weight,
    output logic [PRODUCT_W-1:0] product
);

    logic [OPERAND_W-1:0] pp [OPERAND_W];

    logic [ROW_W-1:0] row_a;
    logic [ROW_W-1:0] row_b;
    logic [ROW_W-1:0] row_c;
    logic [ROW_W-1:0] row_d;
    logic [ROW_W-1:0] row_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // partial products, one gated copy of the weight per bit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < OPERAND_W; i++) begin
            pp[i] = weight & {OPERAND_W{activation[i]}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compression of rows 0 to 5 into five sparse rows.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit 12 down to bit 0.
    assign row_a = {
        pp[5][7],
        pp[4][7] & pp[5][6],
        pp[2][7] & pp[3][6],
        pp[2][7] | pp[3][6],
        pp[0][7] | pp[1][6],
        pp[2][4] | pp[3][3],
        pp[2][4] & pp[3][3],
        1'b0,
        pp[0][3] ^ pp[1][2],
        1'b0,
        pp[0][2] & pp[1][1],
        pp[0][1] | pp[1][0],
        1'b0
    };

    assign row_b = {
        1'b0,
        pp[4][7] | pp[5][6],
        pp[3][7],
        pp[4][4] & pp[5][3],
        pp[1][7],
        pp[2][5] ^ pp[3][4],
        pp[4][2] | pp[5][1],
        3'b000,
        pp[2][0],
        2'b00
    };

    // the last three rows only populate bits 8 to 10.
    assign row_c = {
        2'b00,
        pp[4][6] & pp[5][5],
        pp[4][5] & pp[5][4],
        pp[2][6] | pp[3][5],
        8'h00
    };

    assign row_d = {
        2'b00,
        pp[4][6] | pp[5][5],
        pp[4][5] | pp[5][4],
        pp[4][3] | pp[5][2],
        8'h00
    };

    assign row_e = {
        4'h0,
        pp[4][4] ^ pp[5][3],
        8'h00
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // final sum, rows 6 and 7 enter exactly at their weight.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign product = PRODUCT_W'({pp[6], 6'b000000})
                   + PRODUCT_W'({pp[7], 7'b0000000})
                   + PRODUCT_W'(row_a)
                   + PRODUCT_W'(row_b)
                   + PRODUCT_W'(row_c)
                   + PRODUCT_W'(row_d)
                   + PRODUCT_W'(row_e);

endmodule

//--- logic/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo
    import lenet_mac_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          push,
    input  operand_pair_t push_pair,
    input  logic          pop,
    output operand_pair_t pop_pair,
    output logic          not_empty
);

    operand_pair_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_pair  = mem[rd_ptr];
    assign not_empty = (count != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pair;
        end
    end

    // the issuer's credits must keep pushes within the free slots.
    assert property (@(posedge clk) disable iff (reset) push |-> count < CREDIT_W'(FIFO_DEPTH))
        else $error("credit_fifo: push while full");

    assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
        else $error("credit_fifo: pop while empty");

endmodule

//--- logic/lenet_mac_lane.sv
`timescale 1ns/1ps

module lenet_mac_lane
    import lenet_mac_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic [OPERAND_W-1:0] in_activation,
    input  logic [OPERAND_W-1:0] in_weight,
    output logic                 in_ready,
    input  logic                 out_ready,
    output logic                 sum_valid,
    output logic [ACC_W-1:0]     sum
);

    logic          push;
    operand_pair_t push_pair;
    logic          pop;
    operand_pair_t pop_pair;
    logic          not_empty;
    logic          credit_return;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issuer, operand buffer and MAC.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operand_issuer i_issuer (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_activation (in_activation),
        .in_weight     (in_weight),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .push          (push),
        .push_pair     (push_pair)
    );

    credit_fifo i_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_pair (push_pair),
        .pop       (pop),
        .pop_pair  (pop_pair),
        .not_empty (not_empty)
    );

    approx_mac i_mac (
        .clk           (clk),
        .reset         (reset),
        .pop_pair      (pop_pair),
        .not_empty     (not_empty),
        .pop           (pop),
        .credit_return (credit_return),
        .out_ready     (out_ready),
        .sum_valid     (sum_valid),
        .sum           (sum)
    );

endmodule

//--- logic/lenet_mac_pkg.sv
package lenet_mac_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // width of the compressed rows inside the multiplier.
    localparam int ROW_W = 13;

    // one row of a 5x5 kernel per window.
    localparam int TAPS  = 5;
    localparam int TAP_W = $clog2(TAPS);

    // room for TAPS full-scale products.
    localparam int ACC_W = PRODUCT_W + $clog2(TAPS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffering and flow control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    // must hold 0 through FIFO_DEPTH inclusive.
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    // one operand pair, last is set on the final tap of a window.
    typedef struct packed {
        logic [OPERAND_W-1:0] activation;
        logic [OPERAND_W-1:0] weight;
        logic                 last;
    } operand_pair_t;

endpackage

//--- logic/operand_issuer.sv
`timescale 1ns/1ps

module operand_issuer
    import lenet_mac_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic [OPERAND_W-1:0] in_activation,
    input  logic [OPERAND_W-1:0] in_weight,
    output logic                 in_ready,
    input  logic                 credit_return,
    output logic                 push,
    output operand_pair_t        push_pair
);

    logic [CREDIT_W-1:0] credits;
    logic [TAP_W-1:0]    tap_count;
    logic                last_tap;

    // one credit per free FIFO slot.
    assign in_ready = (credits != '0);
    assign push     = in_valid && in_ready;
    assign last_tap = (tap_count == TAP_W'(TAPS - 1));

    assign push_pair = '{activation: in_activation, weight: in_weight, last: last_tap};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit counter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // window position of the next accepted pair.
    always_ff @(posedge clk) begin
        if (reset) begin
            tap_count <= '0;
        end else if (push) begin
            tap_count <= last_tap ? '0 : tap_count + 1'b1;
        end
    end

    // returned credits must never outnumber the FIFO slots.
    assert property (@(posedge clk) disable iff (reset) credits <= CREDIT_W'(FIFO_DEPTH))
        else $error("operand_issuer: credit count %0d above FIFO depth", credits);

endmodule

//--- testbench/lenet_mac_lane_tb.sv
`timescale 1ns/1ps

module lenet_mac_lane_tb
    import lenet_mac_pkg::*;
();

    localparam string PATTERN_FILE      = "testbench/mac_patterns.txt";
    localparam int    CYCLES_PER_WINDOW = 40;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 in_valid;
    logic [OPERAND_W-1:0] in_activation;
    logic [OPERAND_W-1:0] in_weight;
    logic                 in_ready;
    logic                 out_ready;
    logic                 sum_valid;
    logic [ACC_W-1:0]     sum;

    // window data in file order, operands flattened per tap.
    string                name_q [$];
    bit                   bp_q   [$];
    logic [ACC_W-1:0]     exp_q  [$];
    logic [OPERAND_W-1:0] act_q  [$];
    logic [OPERAND_W-1:0] wgt_q  [$];

    int  seed = 73;
    int  window_count;
    int  cycle_count;
    int  cycle_limit;
    int  tests;
    int  errors;
    bit  saw_in_ready_low;
    bit  any_back_pressure;

    lenet_mac_lane i_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_activation (in_activation),
        .in_weight     (in_weight),
        .in_ready      (in_ready),
        .out_ready     (out_ready),
        .sum_valid     (sum_valid),
        .sum           (sum)
    );

    always #50 clk = ~clk;

    // run limit, scaled by the number of windows.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d sums outstanding",
                     cycle_count, exp_q.size());
            $display("test failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pattern loading.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_patterns();
        int    fd;
        int    fields;
        string line;
        string name;
        int    bp;
        int    act [TAPS];
        int    wgt [TAPS];
        int    expected;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d",
                                     name, bp, act[0], act[1], act[2], act[3], act[4],
                                     wgt[0], wgt[1], wgt[2], wgt[3], wgt[4], expected);
                    if (fields == 13) begin
                        name_q.push_back(name);
                        bp_q.push_back(bp != 0);
                        exp_q.push_back(ACC_W'(expected));
                        for (int t = 0; t < TAPS; t++) begin
                            act_q.push_back(OPERAND_W'(act[t]));
                            wgt_q.push_back(OPERAND_W'(wgt[t]));
                        end
                    end else begin
                        $display("malformed pattern line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // pairs go out only while a credit is free.
    task automatic drive_windows(input int count);
        for (int k = 0; k < count; k++) begin
            for (int t = 0; t < TAPS; t++) begin
                @(negedge clk);
                while (!in_ready) begin
                    in_valid = 1'b0;
                    @(negedge clk);
                end
                in_valid      = 1'b1;
                in_activation = act_q[k * TAPS + t];
                in_weight     = wgt_q[k * TAPS + t];
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side, sums are taken at the posedge after out_ready is set.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic collect_sums();
        string            name;
        logic [ACC_W-1:0] expected;
        logic [ACC_W-1:0] held_sum;
        bit               bp;
        bit               held;
        bit               taken;
        held = 1'b0;
        while (exp_q.size() > 0) begin
            name     = name_q.pop_front();
            expected = exp_q.pop_front();
            bp       = bp_q.pop_front();
            taken    = 1'b0;
            while (!taken) begin
                @(negedge clk);
                if (held) begin
                    assert (sum_valid && sum === held_sum) else begin
                        $display("held sum changed or dropped before it was taken in %s", name);
                        errors++;
                    end
                end
                if (!in_ready) begin
                    saw_in_ready_low = 1'b1;
                end
                out_ready = bp ? (($random(seed) & 7) == 0) : 1'b1;
                held      = sum_valid && !out_ready;
                held_sum  = sum;
                if (sum_valid && out_ready) begin
                    taken = 1'b1;
                    tests++;
                    assert (sum === expected) begin
                        $display("%s: ok, sum %0d", name, sum);
                    end else begin
                        $display("mismatch in %s: expected %0d, actual %0d",
                                 name, expected, sum);
                        errors++;
                    end
                end
            end
        end
    endtask

    initial begin
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_activation = '0;
        in_weight     = '0;
        out_ready     = 1'b0;
        load_patterns();
        window_count = exp_q.size();
        foreach (bp_q[i]) begin
            any_back_pressure |= bp_q[i];
        end
        cycle_limit = CYCLES_PER_WINDOW * window_count + 20;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        tests++;
        assert (in_ready && !sum_valid) begin
            $display("reset_state: ok");
        end else begin
            $display("after reset in_ready is not high or sum_valid is not low");
            errors++;
        end

        fork
            drive_windows(window_count);
            collect_sums();
        join

        if (any_back_pressure) begin
            tests++;
            assert (saw_in_ready_low) begin
                $display("credit_stall: ok");
            end else begin
                $display("in_ready never dropped while sums were held back");
                errors++;
            end
        end

        $display("windows %0d, checks %0d, errors %0d", window_count, tests, errors);
        if (errors == 0 && window_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/mac_patterns.txt
# name backpressure act0 act1 act2 act3 act4 wgt0 wgt1 wgt2 wgt3 wgt4 expected_sum
# all values decimal, expected_sum is the approximate multiplier result summed over the taps
zero_act     0   0   0   0   0   0 255 165  55  80  15      0
zero_wgt     0 255  36  64  10  12   0   0   0   0   0      0
all_ones     0 255 255 255 255 255 255 255 255 255 255 322930
mixed_a      0   1   3   2  16  48   1   3 128  16  24   1794
mixed_b      0 192  12 129  36  10 200  15 255 165  80  78362
mixed_c      0  64 255  36  48  12  55 255 165  24  15  75538
bp_ones      1 255 255 255 255 255 255 255 255 255 255 322930
bp_mixed_b   1 192  12 129  36  10 200  15 255 165  80  78362
bp_mixed_d   1  10 129  64   2   1  80 255  55 128   1  37586
bp_zero      1   0   0   0   0   0 255 255 255 255 255      0
bp_mixed_a   1   1   3   2  16  48   1   3 128  16  24   1794
